// ==== rtl/tcdm_pkg.sv ====
package tcdm_pkg;

  // Memory word and byte lane geometry
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned ByteWidth  = 8;
  localparam int unsigned BeWidth    = DataWidth / ByteWidth; // One enable per byte lane
  localparam int unsigned AddrWidth  = 32;                    // Byte address on the bus side
  localparam int unsigned WordOffset = $clog2(BeWidth);       // Byte-in-word bits, 2

  // Width left once the byte offset is stripped
  localparam int unsigned WordAddrWidth = AddrWidth - WordOffset;

  // Byte address to word address
  function automatic logic [WordAddrWidth-1:0] word_addr(
    input logic [AddrWidth-1:0] addr
  );
    return addr[AddrWidth-1:WordOffset];
  endfunction

  // Expand byte enables into a bit mask over the whole word
  function automatic logic [DataWidth-1:0] be_to_mask(
    input logic [BeWidth-1:0] be
  );
    logic [DataWidth-1:0] mask;
    mask = '0;
    for (int unsigned i = 0; i < BeWidth; i++) begin
      mask[i*ByteWidth +: ByteWidth] = {ByteWidth{be[i]}};
    end
    return mask;
  endfunction

  // Byte offset of an address inside its word
  function automatic logic [WordOffset-1:0] byte_offset(
    input logic [AddrWidth-1:0] addr
  );
    return addr[WordOffset-1:0];
  endfunction

endpackage

// ==== rtl/tcdm_sram_bank.sv ====
`timescale 1ns/1ps

module tcdm_sram_bank #(
  parameter int unsigned BankSize = 64 // Words in this bank, power of two
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_i,   // Access strobe
  input  logic                               we_i,    // 1 = write, 0 = read
  input  logic [$clog2(BankSize)-1:0]        addr_i,  // Word index inside the bank
  input  logic [tcdm_pkg::DataWidth-1:0]     wdata_i,
  input  logic [tcdm_pkg::BeWidth-1:0]       be_i,    // Byte lanes to write
  output logic [tcdm_pkg::DataWidth-1:0]     rdata_o  // Valid one cycle after a read
);

  import tcdm_pkg::*;

  logic [DataWidth-1:0] mem_q [BankSize]; // Storage array, no reset
  logic [DataWidth-1:0] wmask;            // Bit mask from byte enables
  logic [DataWidth-1:0] merged;           // Old word with the new bytes laid in

  assign wmask  = be_to_mask(be_i);
  assign merged = (mem_q[addr_i] & ~wmask) | (wdata_i & wmask);

  // Write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= merged; // Only enabled bytes change
    end
  end

  // Read port, one cycle of latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  // Writes leave rdata_o holding the last read word

endmodule

// ==== rtl/tcdm_banks_wrap.sv ====
`timescale 1ns/1ps

module tcdm_banks_wrap #(
  parameter int unsigned NbBanks  = 4,  // Number of interleaved banks
  parameter int unsigned BankSize = 64, // Words per bank
  parameter int unsigned IdWidth  = 1   // Response id width
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic [NbBanks-1:0]                                req_i,
  input  logic [NbBanks-1:0]                                we_i,
  input  logic [NbBanks-1:0][$clog2(BankSize)-1:0]          addr_i,
  input  logic [NbBanks-1:0][tcdm_pkg::DataWidth-1:0]       wdata_i,
  input  logic [NbBanks-1:0][tcdm_pkg::BeWidth-1:0]         be_i,
  input  logic [NbBanks-1:0][IdWidth-1:0]                   id_i,      // Requester tag
  output logic [NbBanks-1:0]                                gnt_o,
  output logic [NbBanks-1:0][tcdm_pkg::DataWidth-1:0]       r_data_o,
  output logic [NbBanks-1:0][IdWidth-1:0]                   r_id_o     // Tag of last request
);

  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank
    logic [IdWidth-1:0] resp_id_q; // Id follows the data by one cycle

    // A single-port SRAM never stalls
    assign gnt_o[b] = 1'b1;

    // Echo the request id alongside the read data
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        resp_id_q <= '0;
      end else begin
        resp_id_q <= id_i[b];
      end
    end

    assign r_id_o[b] = resp_id_q;

    tcdm_sram_bank #(
      .BankSize (BankSize)
    ) i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .req_i   (req_i[b]),
      .we_i    (we_i[b]),
      .addr_i  (addr_i[b]),     // Already the word index inside this bank
      .wdata_i (wdata_i[b]),
      .be_i    (be_i[b]),
      .rdata_o (r_data_o[b])
    );
  end

endmodule

// ==== rtl/tcdm_interleaver.sv ====
`timescale 1ns/1ps

module tcdm_interleaver #(
  parameter int unsigned NbPorts  = 2,  // Requesters
  parameter int unsigned NbBanks  = 4,  // Banks, power of two
  parameter int unsigned BankSize = 64, // Words per bank
  parameter int unsigned IdWidth  = 1   // Holds a port index
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Port side
  input  logic [NbPorts-1:0]                            req_i,
  input  logic [NbPorts-1:0]                            we_i,
  input  logic [NbPorts-1:0][tcdm_pkg::AddrWidth-1:0]   addr_i,   // Byte address
  input  logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]   wdata_i,
  input  logic [NbPorts-1:0][tcdm_pkg::BeWidth-1:0]     be_i,
  output logic [NbPorts-1:0]                            gnt_o,
  output logic [NbPorts-1:0]                            r_valid_o,
  output logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]   r_data_o,
  // Bank side
  output logic [NbBanks-1:0]                            bank_req_o,
  output logic [NbBanks-1:0]                            bank_we_o,
  output logic [NbBanks-1:0][$clog2(BankSize)-1:0]      bank_addr_o,
  output logic [NbBanks-1:0][tcdm_pkg::DataWidth-1:0]   bank_wdata_o,
  output logic [NbBanks-1:0][tcdm_pkg::BeWidth-1:0]     bank_be_o,
  output logic [NbBanks-1:0][IdWidth-1:0]               bank_id_o,
  input  logic [NbBanks-1:0]                            bank_gnt_i,
  input  logic [NbBanks-1:0][tcdm_pkg::DataWidth-1:0]   bank_r_data_i,
  input  logic [NbBanks-1:0][IdWidth-1:0]               bank_r_id_i
);

  import tcdm_pkg::*;

  localparam int unsigned BankBits = $clog2(NbBanks);  // Low word bits pick the bank
  localparam int unsigned BankAw   = $clog2(BankSize); // Next bits index inside it

  logic [NbPorts-1:0][BankBits-1:0] port_bank; // Target bank per port
  logic [NbPorts-1:0][BankAw-1:0]   port_word; // Word index inside that bank
  logic [NbPorts-1:0][NbBanks-1:0]  port_hit;  // One-hot bank request per port
  logic [NbBanks-1:0][IdWidth-1:0]  rr_q;      // Round-robin priority pointer
  logic [NbBanks-1:0][IdWidth-1:0]  win;       // Winning port per bank
  logic [NbBanks-1:0]               rsp_valid_q; // Bank served someone last cycle
  logic [NbPorts-1:0]               r_valid_q;

  // Address decode per port
  for (genvar p = 0; p < NbPorts; p++) begin : gen_decode
    logic [WordAddrWidth-1:0] waddr;

    assign waddr        = word_addr(addr_i[p]);
    assign port_bank[p] = waddr[BankBits-1:0];
    assign port_word[p] = waddr[BankBits +: BankAw];
    assign port_hit[p]  = {NbBanks{req_i[p]}} & (NbBanks'(1) << port_bank[p]);

    // Granted only if this port won its bank
    assign gnt_o[p] = req_i[p] & bank_req_o[port_bank[p]] & bank_gnt_i[port_bank[p]]
                    & (win[port_bank[p]] == IdWidth'(p));
  end

  // Round-robin search per bank, starting at the pointer
  always_comb begin : arbiter
    int unsigned idx;
    idx = 0;
    for (int unsigned b = 0; b < NbBanks; b++) begin
      bank_req_o[b] = 1'b0;
      win[b]        = rr_q[b];
      // Walk backwards so the closest requester to the pointer wins last
      for (int k = NbPorts - 1; k >= 0; k--) begin
        idx = int'(rr_q[b]) + k;
        if (idx >= NbPorts) idx = idx - NbPorts; // Wrap
        if (port_hit[idx][b]) begin
          bank_req_o[b] = 1'b1;
          win[b]        = IdWidth'(idx);
        end
      end
    end
  end

  // Mux the winner's payload onto each bank
  for (genvar b = 0; b < NbBanks; b++) begin : gen_bank_mux
    assign bank_we_o[b]    = we_i[win[b]];
    assign bank_addr_o[b]  = port_word[win[b]];
    assign bank_wdata_o[b] = wdata_i[win[b]];
    assign bank_be_o[b]    = be_i[win[b]];
    assign bank_id_o[b]    = win[b]; // Tag comes back as r_id
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q        <= '0;
      rsp_valid_q <= '0;
      r_valid_q   <= '0;
    end else begin
      r_valid_q <= gnt_o; // Response one cycle after grant
      for (int unsigned b = 0; b < NbBanks; b++) begin
        rsp_valid_q[b] <= bank_req_o[b] & bank_gnt_i[b];
        if (bank_req_o[b] && bank_gnt_i[b]) begin
          // Move priority just past the winner
          rr_q[b] <= (win[b] == IdWidth'(NbPorts - 1)) ? '0 : win[b] + 1'b1;
        end
      end
    end
  end

  // Response routing by returned id
  // Only banks that served a request last cycle take part, stale ids are ignored
  always_comb begin
    for (int unsigned p = 0; p < NbPorts; p++) begin
      r_data_o[p] = '0;
      for (int unsigned b = 0; b < NbBanks; b++) begin
        if (rsp_valid_q[b] && bank_r_id_i[b] == IdWidth'(p)) begin
          r_data_o[p] = bank_r_data_i[b];
        end
      end
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

// ==== rtl/wb_tcdm_bridge.sv ====
`timescale 1ns/1ps

module wb_tcdm_bridge (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Wishbone classic slave
  input  logic                             cyc_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [tcdm_pkg::AddrWidth-1:0]   adr_i,
  input  logic [tcdm_pkg::DataWidth-1:0]   dat_i,
  input  logic [tcdm_pkg::BeWidth-1:0]     sel_i,
  output logic [tcdm_pkg::DataWidth-1:0]   dat_o,
  output logic                             ack_o,
  // TCDM master
  output logic                             req_o,
  output logic                             we_o,
  output logic [tcdm_pkg::AddrWidth-1:0]   addr_o,
  output logic [tcdm_pkg::DataWidth-1:0]   wdata_o,
  output logic [tcdm_pkg::BeWidth-1:0]     be_o,
  input  logic                             gnt_i,
  input  logic                             r_valid_i,
  input  logic [tcdm_pkg::DataWidth-1:0]   r_data_i
);

  logic outstanding_q; // Granted, waiting for r_valid
  logic wb_active;     // Master has a cycle in progress

  assign wb_active = cyc_i & stb_i;

  // Request once per Wishbone cycle
  assign req_o   = wb_active & ~outstanding_q;
  assign we_o    = we_i;
  assign addr_o  = adr_i;   // Byte address, decoded downstream
  assign wdata_o = dat_i;
  assign be_o    = sel_i;

  // Set on the handshake, clear when the response arrives
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (req_o && gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (r_valid_i) begin
      outstanding_q <= 1'b0; // Cycle ends with this ack
    end
  end

  // Ack only for our own response and only while the master still waits
  assign ack_o = r_valid_i & outstanding_q & wb_active;
  assign dat_o = r_data_i; // Read data, meaningful with ack on a read

endmodule

// ==== rtl/tcdm_subsys_top.sv ====
`timescale 1ns/1ps

module tcdm_subsys_top #(
  parameter int unsigned NbPorts  = 2,
  parameter int unsigned NbBanks  = 4,
  parameter int unsigned BankSize = 64,
  parameter int unsigned IdWidth  = 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic [NbPorts-1:0]                            wb_cyc_i,
  input  logic [NbPorts-1:0]                            wb_stb_i,
  input  logic [NbPorts-1:0]                            wb_we_i,
  input  logic [NbPorts-1:0][tcdm_pkg::AddrWidth-1:0]   wb_adr_i,
  input  logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]   wb_dat_i,
  input  logic [NbPorts-1:0][tcdm_pkg::BeWidth-1:0]     wb_sel_i,
  output logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]   wb_dat_o,
  output logic [NbPorts-1:0]                            wb_ack_o
);

  import tcdm_pkg::*;

  // Bridge to interleaver
  logic [NbPorts-1:0]                 tcdm_req, tcdm_we, tcdm_gnt, tcdm_r_valid;
  logic [NbPorts-1:0][AddrWidth-1:0]  tcdm_addr;
  logic [NbPorts-1:0][DataWidth-1:0]  tcdm_wdata, tcdm_r_data;
  logic [NbPorts-1:0][BeWidth-1:0]    tcdm_be;

  // Interleaver to banks
  logic [NbBanks-1:0]                        bank_req, bank_we, bank_gnt;
  logic [NbBanks-1:0][$clog2(BankSize)-1:0]  bank_addr;
  logic [NbBanks-1:0][DataWidth-1:0]         bank_wdata, bank_r_data;
  logic [NbBanks-1:0][BeWidth-1:0]           bank_be;
  logic [NbBanks-1:0][IdWidth-1:0]           bank_id, bank_r_id;

  for (genvar p = 0; p < NbPorts; p++) begin : gen_bridge
    wb_tcdm_bridge i_bridge (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .cyc_i     (wb_cyc_i[p]),
      .stb_i     (wb_stb_i[p]),
      .we_i      (wb_we_i[p]),
      .adr_i     (wb_adr_i[p]),
      .dat_i     (wb_dat_i[p]),
      .sel_i     (wb_sel_i[p]),
      .dat_o     (wb_dat_o[p]),
      .ack_o     (wb_ack_o[p]),
      .req_o     (tcdm_req[p]),
      .we_o      (tcdm_we[p]),
      .addr_o    (tcdm_addr[p]),
      .wdata_o   (tcdm_wdata[p]),
      .be_o      (tcdm_be[p]),
      .gnt_i     (tcdm_gnt[p]),
      .r_valid_i (tcdm_r_valid[p]),
      .r_data_i  (tcdm_r_data[p])
    );
  end

  tcdm_interleaver #(
    .NbPorts  (NbPorts),
    .NbBanks  (NbBanks),
    .BankSize (BankSize),
    .IdWidth  (IdWidth)
  ) i_interleaver (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (tcdm_req),
    .we_i          (tcdm_we),
    .addr_i        (tcdm_addr),
    .wdata_i       (tcdm_wdata),
    .be_i          (tcdm_be),
    .gnt_o         (tcdm_gnt),
    .r_valid_o     (tcdm_r_valid),
    .r_data_o      (tcdm_r_data),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_addr_o   (bank_addr),
    .bank_wdata_o  (bank_wdata),
    .bank_be_o     (bank_be),
    .bank_id_o     (bank_id),
    .bank_gnt_i    (bank_gnt),
    .bank_r_data_i (bank_r_data),
    .bank_r_id_i   (bank_r_id)
  );

  tcdm_banks_wrap #(
    .NbBanks  (NbBanks),
    .BankSize (BankSize),
    .IdWidth  (IdWidth)
  ) i_banks (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bank_req),
    .we_i     (bank_we),
    .addr_i   (bank_addr),
    .wdata_i  (bank_wdata),
    .be_i     (bank_be),
    .id_i     (bank_id),
    .gnt_o    (bank_gnt),
    .r_data_o (bank_r_data),
    .r_id_o   (bank_r_id)
  );

endmodule

// ==== tb/tcdm_clk_gen.sv ====
`timescale 1ns/1ps

module tcdm_clk_gen #(
  parameter int unsigned PeriodNs    = 40, // Clock period
  parameter int unsigned ResetCycles = 10  // Cycles held in reset
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Active-low reset, released on a falling edge away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== tb/tcdm_assert.sv ====
`timescale 1ns/1ps

module tcdm_checker #(
  parameter int unsigned NbPorts  = 2,
  parameter int unsigned NbBanks  = 4,
  parameter int unsigned BankSize = 64
) (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input logic [NbPorts-1:0]                           wb_cyc_i,
  input logic [NbPorts-1:0]                           wb_stb_i,
  input logic [NbPorts-1:0]                           wb_we_i,
  input logic [NbPorts-1:0][tcdm_pkg::AddrWidth-1:0]  wb_adr_i,
  input logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]  wb_dat_i,
  input logic [NbPorts-1:0][tcdm_pkg::BeWidth-1:0]    wb_sel_i,
  input logic [NbPorts-1:0][tcdm_pkg::DataWidth-1:0]  wb_rdat_i, // Read data from the DUT
  input logic [NbPorts-1:0]                           wb_ack_i
);

  import tcdm_pkg::*;

  localparam int unsigned Words    = NbBanks * BankSize; // Whole memory in words
  localparam int unsigned WordAw   = $clog2(Words);
  localparam int unsigned BankBits = $clog2(NbBanks);

  logic [DataWidth-1:0]             shadow_q [Words]; // Expected memory image
  logic [Words-1:0]                 known_q;          // Word fully written at least once
  logic [NbPorts-1:0][WordAw-1:0]   widx;             // Word index per port
  logic [NbPorts-1:0][BankBits-1:0] bank;             // Target bank per port
  logic [NbPorts-1:0]               active;           // Cycle in progress
  int unsigned                      err_cnt = 0;      // Failed assertions so far

  for (genvar p = 0; p < NbPorts; p++) begin : gen_decode
    assign widx[p]   = wb_adr_i[p][WordOffset +: WordAw];
    assign bank[p]   = widx[p][BankBits-1:0]; // Low word bits interleave the banks
    assign active[p] = wb_cyc_i[p] & wb_stb_i[p];
  end

  // Acked writes update the image lane by lane
  always_ff @(posedge clk_i) begin
    for (int unsigned p = 0; p < NbPorts; p++) begin
      if (rst_ni && wb_ack_i[p] && wb_we_i[p]) begin
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (wb_sel_i[p][b]) begin
            shadow_q[widx[p]][b*ByteWidth +: ByteWidth] <= wb_dat_i[p][b*ByteWidth +: ByteWidth];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      known_q <= '0;
    end else begin
      for (int unsigned p = 0; p < NbPorts; p++) begin
        if (wb_ack_i[p] && wb_we_i[p] && (&wb_sel_i[p])) known_q[widx[p]] <= 1'b1;
      end
    end
  end

  for (genvar p = 0; p < NbPorts; p++) begin : gen_port
    logic [DataWidth-1:0] expect_word; // Shadow word at this port's address
    logic                 expect_known;
    logic                 conflict;    // Other port wants the same bank

    assign expect_word  = shadow_q[widx[p]];
    assign expect_known = known_q[widx[p]];

    always_comb begin
      conflict = 1'b0;
      for (int q = 0; q < NbPorts; q++) begin
        if (q != p && active[q] && bank[q] == bank[p]) conflict = 1'b1;
      end
    end

    read_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_i[p] && !wb_we_i[p] && expect_known |-> wb_rdat_i[p] == expect_word)
      else begin
        err_cnt++;
        $error("ERR %0t: port %0d read %h, shadow %h", $time, p, wb_rdat_i[p], expect_word);
      end

    // Ack only inside a cycle that was already open on the previous edge
    ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_i[p] |-> active[p] && $past(active[p]))
      else begin
        err_cnt++;
        $error("ERR %0t: port %0d ack outside of a cycle", $time, p);
      end

    ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
      wb_ack_i[p] |=> !wb_ack_i[p])
      else begin
        err_cnt++;
        $error("ERR %0t: port %0d ack longer than one cycle", $time, p);
      end

    // Without a bank conflict the answer comes one cycle after stb
    // A new request starts after an idle edge or right behind the previous ack
    ack_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      active[p] && !($past(active[p]) && !$past(wb_ack_i[p])) && !conflict |=> wb_ack_i[p])
      else begin
        err_cnt++;
        $error("ERR %0t: port %0d ack late without conflict", $time, p);
      end
  end

endmodule

bind tcdm_subsys_top tcdm_checker #(
  .NbPorts  (NbPorts),
  .NbBanks  (NbBanks),
  .BankSize (BankSize)
) i_checker (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_we_i   (wb_we_i),
  .wb_adr_i  (wb_adr_i),
  .wb_dat_i  (wb_dat_i),
  .wb_sel_i  (wb_sel_i),
  .wb_rdat_i (wb_dat_o),
  .wb_ack_i  (wb_ack_o)
);

// ==== tb/tcdm_tb.sv ====
`timescale 1ns/1ps

module tcdm_tb;

  import tcdm_pkg::*;

  localparam int unsigned NbPorts    = 2;
  localparam int unsigned NbBanks    = 4;
  localparam int unsigned BankSize   = 64;
  localparam int unsigned IdWidth    = 1;
  localparam int unsigned Words      = NbBanks * BankSize; // Whole memory
  localparam int unsigned AckTimeout = 40;                  // Cycles allowed per ack

  logic                               clk;
  logic                               rst_n;
  logic [NbPorts-1:0]                 wb_cyc;
  logic [NbPorts-1:0]                 wb_stb;
  logic [NbPorts-1:0]                 wb_we;
  logic [NbPorts-1:0][AddrWidth-1:0]  wb_adr;
  logic [NbPorts-1:0][DataWidth-1:0]  wb_dat;
  logic [NbPorts-1:0][BeWidth-1:0]    wb_sel;
  logic [NbPorts-1:0][DataWidth-1:0]  wb_rdat;
  logic [NbPorts-1:0]                 wb_ack;
  integer                             seed;   // Random state

  tcdm_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_subsys_top #(
    .NbPorts  (NbPorts),
    .NbBanks  (NbBanks),
    .BankSize (BankSize),
    .IdWidth  (IdWidth)
  ) DUT (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack)
  );

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "No response from the DUT");
  endtask

  function automatic logic [DataWidth-1:0] rand_data();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic int unsigned rand_word();
    return rand_data() % Words;
  endfunction

  // Every address bit shapes the word
  function automatic logic [DataWidth-1:0] fill_word(input int unsigned word);
    return (word * 32'h9E37_79B1) ^ 32'hC0DE_0000;
  endfunction

  // One classic cycle on port p, held until ack
  // Starts on the current falling edge, so calls in a row run back to back
  task automatic wb_cycle(input int p, input logic we, input int unsigned word,
                          input logic [DataWidth-1:0] dat, input logic [BeWidth-1:0] sel);
    int unsigned cnt;
    cnt = 0;
    wb_cyc[p] = 1'b1;
    wb_stb[p] = 1'b1;
    wb_we[p]  = we;
    wb_adr[p] = AddrWidth'(word) << WordOffset;
    wb_dat[p] = dat;
    wb_sel[p] = sel;
    @(negedge clk);
    while (!wb_ack[p]) begin
      cnt++;
      if (cnt > AckTimeout) stop_on_timeout($sformatf("ack on port %0d", p));
      @(negedge clk);
    end
    @(negedge clk); // Ack is sampled on the rising edge in between
    wb_cyc[p] = 1'b0;
    wb_stb[p] = 1'b0;
    wb_we[p]  = 1'b0;
  endtask

  // Both ports start on the same edge
  task automatic wb_pair(input logic we0, input int unsigned w0, input logic [DataWidth-1:0] d0,
                         input logic [BeWidth-1:0] s0, input logic we1, input int unsigned w1,
                         input logic [DataWidth-1:0] d1, input logic [BeWidth-1:0] s1);
    fork
      wb_cycle(0, we0, w0, d0, s0);
      wb_cycle(1, we1, w1, d1, s1);
    join
  endtask

  // Checker errors end the run at once
  always @(negedge clk) begin : error_watch
    if (DUT.i_checker.err_cnt != 0) begin
      $display("ERR %0t: checker reported %0d failed assertions", $time, DUT.i_checker.err_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped on checker error");
    end
  end

  initial begin : stimulus
    int unsigned cnt;
    int unsigned w;
    int unsigned w0;
    int unsigned w1;
    logic [DataWidth-1:0] d0;
    logic [DataWidth-1:0] d1;
    seed   = 67;
    wb_cyc = '0;
    wb_stb = '0;
    wb_we  = '0;
    wb_adr = '0;
    wb_dat = '0;
    wb_sel = '0;
    cnt    = 0;
    while (rst_n !== 1'b1) begin
      cnt++;
      if (cnt > 20) stop_on_timeout("reset release");
      @(negedge clk);
    end
    repeat (3) @(negedge clk); // Idle after reset, no ack expected

    // Full words into every bank from port 0, then read back
    for (w = 0; w < Words; w++) wb_cycle(0, 1'b1, w, fill_word(w), {BeWidth{1'b1}});
    for (w = 0; w < Words; w++) wb_cycle(0, 1'b0, w, '0, '0);

    // Random byte lanes
    for (int i = 0; i < 40; i++) begin
      w  = rand_word();
      d0 = rand_data();
      d1 = rand_data();
      wb_cycle(0, 1'b1, w, d0, d1[BeWidth-1:0]);
      wb_cycle(0, 1'b0, w, '0, '0);
    end

    // Same bank on both ports, other row
    for (int i = 0; i < 20; i++) begin
      w0 = rand_word();
      w1 = (w0 + NbBanks * (i + 1)) % Words;
      d0 = rand_data();
      d1 = rand_data();
      wb_pair(1'b1, w0, d0, {BeWidth{1'b1}}, 1'b1, w1, d1, {BeWidth{1'b1}});
      wb_pair(1'b0, w1, '0, '0, 1'b0, w0, '0, '0); // Each reads the other's word
    end

    // Different banks, one-cycle acks
    for (int i = 0; i < 20; i++) begin
      w0 = rand_word();
      w1 = w0 ^ 1; // Flips the low bank bit
      d0 = rand_data();
      d1 = rand_data();
      wb_pair(1'b1, w0, d0, {BeWidth{1'b1}}, 1'b1, w1, d1, {BeWidth{1'b1}});
      wb_pair(1'b0, w0, '0, '0, 1'b0, w1, '0, '0);
    end

    // Random mix over the whole memory
    for (int i = 0; i < 200; i++) begin
      w0 = rand_word();
      w1 = rand_word();
      d0 = rand_data();
      d1 = rand_data();
      wb_pair(d0[31], w0, d0, d1[3:0], d1[31], w1, d1, d0[3:0]);
    end

    repeat (3) @(negedge clk);
    if (DUT.i_checker.err_cnt != 0) begin
      $display("ERR %0t: checker reported %0d failed assertions", $time, DUT.i_checker.err_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "Checker errors at end of run");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
rtl/tcdm_pkg.sv
rtl/tcdm_sram_bank.sv
rtl/tcdm_banks_wrap.sv
rtl/tcdm_interleaver.sv
rtl/wb_tcdm_bridge.sv
rtl/tcdm_subsys_top.sv
tb/tcdm_clk_gen.sv
tb/tcdm_assert.sv
tb/tcdm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TCDM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tcdm_tb -f flist.f -o Vtcdm_tb

# Keep running after an assertion so the testbench can end the run itself
./obj_dir/Vtcdm_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
